//--- dmac.f
dmaPkg.sv
wbPkg.sv
syncFifo.sv
portArbiter.sv
descFetch.sv
xferEngine.sv
dmacTop.sv
wbMem.sv
dmacTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = dmacTb
FILELIST = dmac.f

SOURCES  = $(shell grep -v '^+' $(FILELIST))
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

//--- dmacTb.sv
`timescale 1ns/1ps

module dmacTb;

  localparam dmaPkg::addrT DescBase      = 16'hF000; // slot for single descriptors
  localparam int           TimeoutCycles = 4000;     // per wait for done

  logic         clk         = 1'b0;
  logic         rst         = 1'b1;
  logic         start       = 1'b0;
  dmaPkg::addrT chainPtr    = '0;
  logic         busy;
  logic         done;
  wbPkg::wbReqT northReq;
  wbPkg::wbRspT northRsp;
  wbPkg::wbReqT southReq;
  wbPkg::wbRspT southRsp;
  logic [1:0]   nWait       = '0;
  logic [1:0]   sWait       = '0;
  logic         randomWaits = 1'b0;
  logic [15:0]  waitLfsr    = 16'd47;  // wait state stream
  logic [15:0]  dataLfsr    = 16'd47;  // data pattern stream
  int           checks      = 0;
  int           errors      = 0;
  int           testErrs    = 0;       // errors before current test
  string        curTest     = "";
  logic         timedOut    = 1'b0;
  dmaPkg::dataT srcWords [65536];      // source words as written, by address

  always #10 clk = ~clk; // 20 ns period

  dmacTop dut0 (
    .clk(clk), .rst(rst), .start(start), .chainPtr(chainPtr), .busy(busy), .done(done),
    .northReq(northReq), .northRsp(northRsp), .southReq(southReq), .southRsp(southRsp)
  );

  wbMem nMem (.clk(clk), .rst(rst), .waitCycles(nWait), .req(northReq), .rsp(northRsp));
  wbMem sMem (.clk(clk), .rst(rst), .waitCycles(sWait), .req(southReq), .rsp(southRsp));

  // taps 16 14 13 11
  function automatic logic [15:0] lfsrStep(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // new wait count after every ack, two fresh bits each
  always @(posedge clk)
  begin
    if (!randomWaits)
    begin
      nWait <= '0;
      sWait <= '0;
    end
    else
    begin
      if (northRsp.ack)
      begin
        waitLfsr = lfsrStep(lfsrStep(waitLfsr));
        nWait    <= waitLfsr[1:0];
      end
      if (southRsp.ack)
      begin
        waitLfsr = lfsrStep(lfsrStep(waitLfsr));
        sWait    <= waitLfsr[1:0];
      end
    end
  end

  task automatic randomWord(output dmaPkg::dataT w);
    w = '0;
    for (int b = 0; b < $bits(dmaPkg::dataT); b++)
    begin
      dataLfsr = lfsrStep(dataLfsr);       // one step per bit
      w        = {w[14:0], dataLfsr[0]};
    end
  endtask

  function automatic logic inNorthRegion(dmaPkg::addrT a);
    return a[15:12] == 4'hF;
  endfunction

  function automatic dmaPkg::dataT readMem(dmaPkg::addrT a);
    if (inNorthRegion(a))
      return nMem.peek(a);
    return sMem.peek(a);
  endfunction

  task automatic writeMem(dmaPkg::addrT a, dmaPkg::dataT d);
    if (inNorthRegion(a))
      nMem.poke(a, d);
    else
      sMem.poke(a, d);
  endtask

  // marker for words no copy may touch
  function automatic dmaPkg::dataT guardWord(dmaPkg::addrT a);
    return a ^ 16'hC35A;
  endfunction

  task automatic checkData(string what, dmaPkg::dataT exp, dmaPkg::dataT act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("mismatch %s %s expected %h actual %h", curTest, what, exp, act);
    end
  endtask

  task automatic checkBit(string what, logic exp, logic act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("mismatch %s %s expected %b actual %b", curTest, what, exp, act);
    end
  endtask

  task automatic beginTest(string name);
    curTest  = name;
    testErrs = errors;
  endtask

  task automatic endTest();
    if (errors == testErrs)
      $display("test %s passed", curTest);
    else
      $display("test %s failed with %0d errors", curTest, errors - testErrs);
  endtask

  // six words, fields in struct order, always in north memory
  task automatic putDesc(dmaPkg::addrT at, dmaPkg::descT d);
    nMem.poke(at, d.srcAddr);
    nMem.poke(at + 16'd1, d.srcStride);
    nMem.poke(at + 16'd2, d.dstAddr);
    nMem.poke(at + 16'd3, d.dstStride);
    nMem.poke(at + 16'd4, d.count);
    nMem.poke(at + 16'd5, d.nextPtr);
  endtask

  // random source words plus a guard just past the destination
  task automatic prepCopy(dmaPkg::descT d);
    dmaPkg::dataT w;
    dmaPkg::addrT a;
    dmaPkg::addrT last;
    for (dmaPkg::countT i = 0; i < d.count; i++)
    begin
      randomWord(w);
      a           = d.srcAddr + i * d.srcStride;
      srcWords[a] = w;                     // kept apart from the memory model
      writeMem(a, w);
    end
    last = d.dstAddr + d.count * d.dstStride;
    writeMem(last, guardWord(last));
  endtask

  task automatic checkCopy(string what, dmaPkg::descT d);
    dmaPkg::addrT last;
    for (dmaPkg::countT i = 0; i < d.count; i++)
      checkData($sformatf("%s word %0d", what, i), srcWords[d.srcAddr + i * d.srcStride],
                readMem(d.dstAddr + i * d.dstStride));
    last = d.dstAddr + d.count * d.dstStride;  // first word past the copy
    checkData({what, " guard"}, guardWord(last), readMem(last));
  endtask

  task automatic kick(dmaPkg::addrT ptr);
    @(posedge clk);
    start    <= 1'b1;
    chainPtr <= ptr;
    @(posedge clk);
    start    <= 1'b0;
  endtask

  // busy must hold until done, both sampled mid-cycle
  task automatic waitDone();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!done && cycles < TimeoutCycles)
    begin
      checkBit("busy while running", 1'b1, busy);
      cycles++;
      @(negedge clk);
    end
    if (done)
      checkBit("busy at done", 1'b0, busy);
    else
    begin
      errors++;
      timedOut = 1'b1;
      $display("timeout in %s, no done after %0d cycles", curTest, TimeoutCycles);
    end
  endtask

  task automatic resetTest();
    beginTest("afterReset");
    @(negedge clk);
    checkBit("north cyc", 1'b0, northReq.cyc);
    checkBit("south cyc", 1'b0, southReq.cyc);
    checkBit("busy", 1'b0, busy);
    checkBit("done", 1'b0, done);
    endTest();
  endtask

  task automatic copyTest(string name, dmaPkg::descT d);
    beginTest(name);
    prepCopy(d);
    putDesc(DescBase, d);
    kick(DescBase);
    waitDone();
    if (!timedOut)
      checkCopy(name, d);
    endTest();
  endtask

  // middle descriptor is empty and must leave its destination alone
  task automatic chainTest();
    dmaPkg::descT first;
    dmaPkg::descT skipped;
    dmaPkg::descT third;
    int           extraDone;
    first   = '{16'hF700, 16'd1, 16'h4000, 16'd1, 16'd4, 16'hF020};
    skipped = '{16'h5000, 16'd1, 16'hF800, 16'd1, 16'd0, 16'hF030};
    third   = '{16'h5100, 16'd1, 16'h5200, 16'd1, 16'd5, 16'h0000};
    beginTest("chain");
    prepCopy(first);
    prepCopy(third);
    for (dmaPkg::addrT a = 16'hF800; a < 16'hF804; a++)
      writeMem(a, guardWord(a));
    putDesc(16'hF010, first);
    putDesc(16'hF020, skipped);
    putDesc(16'hF030, third);
    kick(16'hF010);
    waitDone();
    if (!timedOut)
    begin
      extraDone = 0;
      repeat (40)
      begin
        @(negedge clk);
        if (done)
          extraDone++;                     // a second pulse is wrong
      end
      checkBit("single done pulse", 1'b0, extraDone != 0);
      checkCopy("first", first);
      checkCopy("third", third);
      for (dmaPkg::addrT a = 16'hF800; a < 16'hF804; a++)
        checkData($sformatf("skipped dst %h", a), guardWord(a), readMem(a));
    end
    endTest();
  endtask

  initial
  begin
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    resetTest();
    copyTest("northToSouth", '{16'hF100, 16'd1, 16'h1200, 16'd1, 16'd8, 16'h0000});
    if (!timedOut)
      copyTest("southToNorth", '{16'h2000, 16'd2, 16'hF400, 16'd3, 16'd6, 16'h0000});
    if (!timedOut)
      copyTest("northToNorth", '{16'hF500, 16'd1, 16'hF600, 16'd1, 16'd6, 16'h0000});
    if (!timedOut)
      copyTest("southToSouth", '{16'h3000, 16'd1, 16'h3100, 16'd1, 16'd7, 16'h0000});
    if (!timedOut)
      chainTest();
    if (!timedOut)
    begin
      randomWaits = 1'b1;                  // 0 to 3 wait states per access
      copyTest("waitStates", '{16'hF100, 16'd1, 16'h1200, 16'd1, 16'd8, 16'h0000});
      randomWaits = 1'b0;
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

//--- wbMem.sv
`timescale 1ns/1ps

module wbMem (
  input  logic         clk,
  input  logic         rst,
  input  logic [1:0]   waitCycles, // wait states before each ack
  input  wbPkg::wbReqT req,
  output wbPkg::wbRspT rsp
);

  dmaPkg::dataT mem [65536]; // whole 16-bit word space
  logic [1:0]   waitCnt;     // wait states spent on this access

  // ack is registered, write and read data land on the ack edge
  always @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      rsp     <= '0;
      waitCnt <= '0;
    end
    else
    begin
      rsp.ack <= 1'b0;                      // one cycle only
      if (req.cyc && req.stb && !rsp.ack)
      begin
        if (waitCnt >= waitCycles)
        begin
          rsp.ack <= 1'b1;
          waitCnt <= '0;
          if (req.we)
            mem[req.adr] <= req.dat;
          else
            rsp.dat <= mem[req.adr];        // valid with ack
        end
        else
          waitCnt <= waitCnt + 2'd1;
      end
    end
  end

  // backdoor, no bus timing
  task automatic poke(dmaPkg::addrT adr, dmaPkg::dataT dat);
    mem[adr] <= dat;                        // lands at end of time step
  endtask

  function automatic dmaPkg::dataT peek(dmaPkg::addrT adr);
    return mem[adr];
  endfunction

endmodule

//--- dmacTop.sv
`timescale 1ns/1ps

module dmacTop (
  input  logic         clk,
  input  logic         rst,
  input  logic         start,
  input  dmaPkg::addrT chainPtr,
  output logic         busy,
  output logic         done,
  output wbPkg::wbReqT northReq,
  input  wbPkg::wbRspT northRsp,
  output wbPkg::wbReqT southReq,
  input  wbPkg::wbRspT southRsp
);

  dmaPkg::descT       desc;
  logic               go;
  logic               finished;
  wbPkg::wbReqT       fetchReq;
  wbPkg::wbRspT       fetchRsp;
  wbPkg::wbReqT       northRead;
  wbPkg::wbReqT       northWrite;
  wbPkg::wbReqT       southRead;
  wbPkg::wbReqT       southWrite;
  wbPkg::wbRspT       northReadRsp;
  wbPkg::wbRspT       northWriteRsp;
  wbPkg::wbRspT       southReadRsp;
  wbPkg::wbRspT       southWriteRsp;
  wbPkg::wbReqT [2:0] northReqs;  // index 0 wins
  wbPkg::wbRspT [2:0] northRsps;
  wbPkg::wbReqT [1:0] southReqs;
  wbPkg::wbRspT [1:0] southRsps;

  // fetcher first, then write ahead of read so the FIFO drains
  assign northReqs     = {northRead, northWrite, fetchReq};
  assign fetchRsp      = northRsps[0];
  assign northWriteRsp = northRsps[1];
  assign northReadRsp  = northRsps[2];
  assign southReqs     = {southRead, southWrite};
  assign southWriteRsp = southRsps[0];
  assign southReadRsp  = southRsps[1];

  descFetch fetch0 (
    .clk(clk), .rst(rst), .start(start), .chainPtr(chainPtr),
    .fetchReq(fetchReq), .fetchRsp(fetchRsp), .desc(desc), .go(go),
    .finished(finished), .busy(busy), .done(done)
  );

  xferEngine engine0 (
    .clk(clk), .rst(rst), .desc(desc), .go(go), .finished(finished),
    .northRead(northRead), .northWrite(northWrite),
    .southRead(southRead), .southWrite(southWrite),
    .northReadRsp(northReadRsp), .northWriteRsp(northWriteRsp),
    .southReadRsp(southReadRsp), .southWriteRsp(southWriteRsp)
  );

  portArbiter #(.NumReq(3)) northArb (
    .clk(clk), .rst(rst), .req(northReqs), .rsp(northRsps),
    .busReq(northReq), .busRsp(northRsp)
  );

  portArbiter #(.NumReq(2)) southArb (
    .clk(clk), .rst(rst), .req(southReqs), .rsp(southRsps),
    .busReq(southReq), .busRsp(southRsp)
  );

endmodule

//--- xferEngine.sv
`timescale 1ns/1ps

module xferEngine (
  input  logic         clk,
  input  logic         rst,
  input  dmaPkg::descT desc,
  input  logic         go,
  output logic         finished,
  output wbPkg::wbReqT northRead,
  output wbPkg::wbReqT northWrite,
  output wbPkg::wbReqT southRead,
  output wbPkg::wbReqT southWrite,
  input  wbPkg::wbRspT northReadRsp,
  input  wbPkg::wbRspT northWriteRsp,
  input  wbPkg::wbRspT southReadRsp,
  input  wbPkg::wbRspT southWriteRsp
);

  dmaPkg::addrT  rdAddr;    // next source word
  dmaPkg::addrT  rdStride;
  dmaPkg::countT rdCount;   // reads still to issue
  dmaPkg::addrT  wrAddr;    // next destination word
  dmaPkg::addrT  wrStride;
  dmaPkg::countT wrCount;   // writes still to finish
  logic          rdPend;    // read strobe up, waiting for ack
  logic          wrPend;    // write strobe up, waiting for ack
  logic          rdNorth;   // source region
  logic          wrNorth;   // destination region
  logic          rdAck;
  logic          wrAck;
  logic          fifoFull;
  logic          fifoEmpty;
  dmaPkg::dataT  headData;  // FIFO head, the data of the pending write
  wbPkg::wbReqT  readReq;
  wbPkg::wbReqT  writeReq;
  wbPkg::wbRspT  readRsp;
  wbPkg::wbRspT  writeRsp;

  assign readRsp  = rdNorth ? northReadRsp : southReadRsp;
  assign writeRsp = wrNorth ? northWriteRsp : southWriteRsp;
  assign rdAck    = rdPend && readRsp.ack;
  assign wrAck    = wrPend && writeRsp.ack;

  assign readReq  = '{cyc: rdPend, stb: rdPend, we: 1'b0, adr: rdAddr, dat: '0};
  assign writeReq = '{cyc: wrPend, stb: wrPend, we: 1'b1, adr: wrAddr, dat: headData};

  // only the selected port of each pair ever sees a strobe
  assign northRead  = rdNorth ? readReq : wbPkg::ReqIdle;
  assign southRead  = rdNorth ? wbPkg::ReqIdle : readReq;
  assign northWrite = wrNorth ? writeReq : wbPkg::ReqIdle;
  assign southWrite = wrNorth ? wbPkg::ReqIdle : writeReq;

  syncFifo fifo0 (
    .clk    (clk),
    .rst    (rst),
    .wrEn   (rdAck),        // acked read data goes straight in
    .wrData (readRsp.dat),
    .rdEn   (wrAck),        // pop once the write lands
    .rdData (headData),
    .full   (fifoFull),
    .empty  (fifoEmpty)
  );

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      rdPend   <= 1'b0;
      wrPend   <= 1'b0;
      rdCount  <= '0;
      wrCount  <= '0;
      rdNorth  <= 1'b0;
      wrNorth  <= 1'b0;
      finished <= 1'b0;
    end
    else if (go)
    begin
      rdCount  <= desc.count;
      wrCount  <= desc.count;
      rdNorth  <= dmaPkg::isNorth(desc.srcAddr);
      wrNorth  <= dmaPkg::isNorth(desc.dstAddr);
      finished <= 1'b0;
    end
    else
    begin
      finished <= 1'b0;
      if (rdAck)
      begin
        rdPend  <= 1'b0;
        rdCount <= rdCount - 1'b1;
      end
      else if (!rdPend && rdCount != '0 && !fifoFull)
        rdPend <= 1'b1;                     // room for the word in flight
      if (wrAck)
      begin
        wrPend   <= 1'b0;
        wrCount  <= wrCount - 1'b1;
        finished <= wrCount == dmaPkg::countT'(1); // last write acked
      end
      else if (!wrPend && wrCount != '0 && !fifoEmpty)
        wrPend <= 1'b1;                     // head word ready
    end
  end

  // address stepping, stride may be any value
  always_ff @(posedge clk)
  begin
    if (go)
    begin
      rdAddr   <= desc.srcAddr;
      rdStride <= desc.srcStride;
      wrAddr   <= desc.dstAddr;
      wrStride <= desc.dstStride;
    end
    else
    begin
      if (rdAck)
        rdAddr <= rdAddr + rdStride;
      if (wrAck)
        wrAddr <= wrAddr + wrStride;
    end
  end

  // an ack only comes back for a strobe we raised with words left
  readCountOk: assert property (
    @(posedge clk) disable iff (rst)
    readRsp.ack |-> rdPend && rdCount != '0
  ) else $error("xferEngine: read count underflow");

  writeCountOk: assert property (
    @(posedge clk) disable iff (rst)
    writeRsp.ack |-> wrPend && wrCount != '0
  ) else $error("xferEngine: write count underflow");

  // every word read has been written by the end
  drainedAtFinish: assert property (
    @(posedge clk) disable iff (rst)
    finished |-> rdCount == '0 && fifoEmpty
  ) else $error("xferEngine: data left behind at finish");

endmodule

//--- descFetch.sv
`timescale 1ns/1ps

module descFetch (
  input  logic         clk,
  input  logic         rst,
  input  logic         start,
  input  dmaPkg::addrT chainPtr,
  output wbPkg::wbReqT fetchReq,
  input  wbPkg::wbRspT fetchRsp,
  output dmaPkg::descT desc,
  output logic         go,
  input  logic         finished,
  output logic         busy,
  output logic         done
);

  typedef enum logic [1:0] {Idle, Fetch, Run, Next} stateT;

  stateT        state;
  logic [2:0]   wordIdx;      // descriptor word being read
  logic [6:0]   fieldLsb;     // bit position of that word in desc
  logic         fetchPend;    // read strobe up
  logic         fetchAck;
  logic         lastWord;
  logic         engineActive; // between go and finished
  dmaPkg::addrT fetchAddr;    // walks the descriptor words

  assign fetchAck = fetchPend && fetchRsp.ack;
  assign lastWord = wordIdx == 3'(dmaPkg::DescWords - 1);
  assign fieldLsb = 7'((dmaPkg::DescWords - 1 - int'(wordIdx)) * $bits(dmaPkg::dataT));
  assign fetchReq = '{cyc: fetchPend, stb: fetchPend, we: 1'b0, adr: fetchAddr, dat: '0};

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state        <= Idle;
      wordIdx      <= '0;
      fetchPend    <= 1'b0;
      go           <= 1'b0;
      busy         <= 1'b0;
      done         <= 1'b0;
      engineActive <= 1'b0;
    end
    else
    begin
      go   <= 1'b0;
      done <= 1'b0;
      if (go)
        engineActive <= 1'b1;
      else if (finished)
        engineActive <= 1'b0;
      case (state)
        Idle:
        begin
          if (start)                 // only seen while not busy
          begin
            busy    <= 1'b1;
            wordIdx <= '0;
            state   <= Fetch;
          end
        end
        Fetch:
        begin
          if (fetchAck)
          begin
            fetchPend <= 1'b0;        // one read at a time
            wordIdx   <= wordIdx + 1'b1;
            if (lastWord)
            begin
              go    <= desc.count != '0;  // count came in one word earlier
              state <= (desc.count != '0) ? Run : Next;
            end
          end
          else if (!fetchPend)
            fetchPend <= 1'b1;
        end
        Run:
        begin
          if (finished)
            state <= Next;
        end
        Next:
        begin
          if (desc.nextPtr == '0)    // end of chain
          begin
            busy  <= 1'b0;
            done  <= 1'b1;
            state <= Idle;
          end
          else
          begin
            wordIdx <= '0;
            state   <= Fetch;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  // pointer and descriptor words
  always_ff @(posedge clk)
  begin
    if (state == Idle && start)
      fetchAddr <= chainPtr;
    else if (state == Next)
      fetchAddr <= desc.nextPtr;
    else if (fetchAck)
      fetchAddr <= fetchAddr + 1'b1;
    if (fetchAck)
      desc[fieldLsb +: $bits(dmaPkg::dataT)] <= fetchRsp.dat;
  end

  // engine must be done before the next descriptor is handed over
  goAfterFinish: assert property (
    @(posedge clk) disable iff (rst)
    go |-> !engineActive
  ) else $error("descFetch: go while engine still running");

  finishedOnlyInRun: assert property (
    @(posedge clk) disable iff (rst)
    finished |-> engineActive && state == Run
  ) else $error("descFetch: stray finished");

endmodule

//--- portArbiter.sv
`timescale 1ns/1ps

module portArbiter #(
  parameter int NumReq = 2
) (
  input  logic                      clk,
  input  logic                      rst,
  input  wbPkg::wbReqT [NumReq-1:0] req,
  output wbPkg::wbRspT [NumReq-1:0] rsp,
  output wbPkg::wbReqT              busReq,
  input  wbPkg::wbRspT              busRsp
);

  logic [NumReq-1:0] grant; // one-hot, zero when the port is free
  logic [NumReq-1:0] pick;  // winner among pending strobes

  // lowest index wins, so scan from the top down
  always_comb
  begin
    pick = '0;
    for (int i = NumReq - 1; i >= 0; i--)
    begin
      if (req[i].cyc && req[i].stb)
      begin
        pick    = '0;
        pick[i] = 1'b1;
      end
    end
  end

  // grant is taken only while free, dropped the cycle after ack
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      grant <= '0;
    else if (grant == '0)
      grant <= pick;          // registered, one cycle after stb
    else if (busRsp.ack)
      grant <= '0;            // free again next cycle
  end

  // granted request straight out, ack straight back
  always_comb
  begin
    busReq = wbPkg::ReqIdle;
    for (int i = 0; i < NumReq; i++)
    begin
      rsp[i]     = wbPkg::RspIdle;
      rsp[i].dat = busRsp.dat;  // data fans out, ack does not
      if (grant[i])
      begin
        busReq     = req[i];
        rsp[i].ack = busRsp.ack;
      end
    end
  end

  grantOneHot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(grant)
  ) else $error("portArbiter: grant not one-hot");

  // slave must not answer a cycle nobody owns
  ackOnlyGranted: assert property (
    @(posedge clk) disable iff (rst)
    busRsp.ack |-> grant != '0
  ) else $error("portArbiter: ack without grant");

endmodule

//--- syncFifo.sv
`timescale 1ns/1ps

module syncFifo (
  input  logic         clk,
  input  logic         rst,
  input  logic         wrEn,
  input  dmaPkg::dataT wrData,
  input  logic         rdEn,
  output dmaPkg::dataT rdData,
  output logic         full,
  output logic         empty
);

  dmaPkg::dataT    mem [dmaPkg::FifoDepth]; // circular storage
  dmaPkg::fifoPtrT wrPtr;                    // next slot to fill
  dmaPkg::fifoPtrT rdPtr;                    // current head
  dmaPkg::fifoPtrT level;                    // entries held

  assign level  = wrPtr - rdPtr;  // wrap bit keeps full and empty apart
  assign full   = level == dmaPkg::fifoPtrT'(dmaPkg::FifoDepth);
  assign empty  = level == '0;
  assign rdData = mem[rdPtr[dmaPkg::FifoIdxW-1:0]]; // head shows without a read

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
    end
    else
    begin
      if (wrEn)
        wrPtr <= wrPtr + 1'b1;
      if (rdEn)
        rdPtr <= rdPtr + 1'b1; // pop, next head visible next cycle
    end
  end

  always_ff @(posedge clk)
  begin
    if (wrEn)
      mem[wrPtr[dmaPkg::FifoIdxW-1:0]] <= wrData;
  end

  noOverflow: assert property (
    @(posedge clk) disable iff (rst) wrEn |-> !full
  ) else $error("syncFifo: write while full");

  noUnderflow: assert property (
    @(posedge clk) disable iff (rst) rdEn |-> !empty
  ) else $error("syncFifo: read while empty");

endmodule

//--- wbPkg.sv
package wbPkg;

  // master to slave, held steady until ack
  typedef struct packed {
    logic         cyc;
    logic         stb;
    logic         we;
    dmaPkg::addrT adr;
    dmaPkg::dataT dat; // write data, don't care on reads
  } wbReqT;

  // slave to master, ack is a single cycle
  typedef struct packed {
    logic         ack;
    dmaPkg::dataT dat; // read data, valid with ack
  } wbRspT;

  localparam wbReqT ReqIdle = '0; // no cycle on the bus
  localparam wbRspT RspIdle = '0; // what an ungranted master sees

endpackage

//--- dmaPkg.sv
package dmaPkg;

  localparam int AddrW = 16;
  localparam int DataW = 16;

  typedef logic [AddrW-1:0] addrT;  // memory word address
  typedef logic [DataW-1:0] dataT;  // one data word
  typedef logic [15:0]      countT; // words left to move

  // field order is also the word order in memory
  typedef struct packed {
    addrT  srcAddr;
    addrT  srcStride;
    addrT  dstAddr;
    addrT  dstStride;
    countT count;
    addrT  nextPtr;   // zero ends the chain
  } descT;

  localparam int DescWords = 6;            // words per descriptor in memory

  localparam logic [3:0] RegionNibble = 4'hF; // top nibble of north addresses

  // depth is kept a power of two so the wrap bit works
  localparam int FifoDepth = 4;
  localparam int FifoIdxW  = $clog2(FifoDepth);

  typedef logic [$clog2(FifoDepth+1)-1:0] fifoPtrT; // index plus wrap bit

  // north port when the top nibble matches, south otherwise
  function automatic logic isNorth(addrT adr);
    return adr[AddrW-1 -: 4] == RegionNibble;
  endfunction

endpackage
